//--- burst_planner.sv
module burst_planner
  import dma_pkg::*;
(
  input  logic        CLK0,
  input  logic        RST0,
  input  logic        plan_load,
  input  ext_addr_t   cmd_addr,
  input  word_count_t cmd_words,
  input  logic        plan_advance,
  output ext_addr_t   cur_addr,
  output blen_t       burst_len,
  output logic        plan_done
);

  ext_addr_t   addr_q;
  word_count_t words_q;      // words still to move
  bwords_t     to_boundary;  // words up to the next 4 KB line
  word_count_t len_min;

  assign to_boundary = bwords_t'(BOUNDARY_WORDS) -
                       {1'b0, addr_q[W_BOUNDARY_A-1:ADDR_OFFSET]};

  // three-way minimum
  always_comb begin
    len_min = words_q;
    if (word_count_t'(to_boundary) < len_min) begin
      len_min = word_count_t'(to_boundary);
    end
    if (word_count_t'(MAX_BURST_LEN) < len_min) begin
      len_min = word_count_t'(MAX_BURST_LEN);
    end
  end

  assign burst_len = blen_t'(len_min);  // never above 256
  assign cur_addr  = addr_q;
  assign plan_done = (words_q == '0);

  // --------------------
  // address and word count
  // --------------------
  always_ff @(posedge CLK0) begin
    if (RST0) begin
      addr_q  <= '0;
      words_q <= '0;
    end else if (plan_load) begin
      addr_q  <= cmd_addr;
      words_q <= cmd_words;
    end else if (plan_advance) begin
      addr_q  <= addr_q + (ext_addr_t'(burst_len) << ADDR_OFFSET);  // words to bytes
      words_q <= words_q - word_count_t'(burst_len);
    end
  end

endmodule

//--- cmd_fifo.sv
module cmd_fifo
  import dma_pkg::*;
(
  input  logic     CLK0,
  input  logic     RST0,
  input  logic     enq,
  input  dma_cmd_t din,
  output logic     full,
  output logic     almost_full,
  input  logic     deq,
  output dma_cmd_t dout,
  output logic     empty
);

  typedef logic [CMD_FIFO_AW-1:0] ptr_t;

  dma_cmd_t mem [CMD_SLOTS];
  ptr_t     head;
  ptr_t     tail;
  ptr_t     rd_addr;  // registered read address
  ptr_t     head_nx;
  ptr_t     tail_nx;
  ptr_t     used_nx;
  logic     do_enq;
  logic     do_deq;

  assign do_enq = enq && !full;
  assign do_deq = deq && !empty;

  // pointers wrap naturally at 2**CMD_FIFO_AW
  assign head_nx = do_deq ? head + 1'b1 : head;
  assign tail_nx = do_enq ? tail + 1'b1 : tail;
  assign used_nx = tail_nx - head_nx;  // occupancy after this cycle

  // --------------------
  // storage
  // --------------------
  always_ff @(posedge CLK0) begin
    if (do_enq) begin
      mem[tail] <= din;
    end
    rd_addr <= head;
  end

  assign dout = mem[rd_addr];

  // --------------------
  // pointers and flags
  // --------------------
  always_ff @(posedge CLK0) begin
    if (RST0) begin
      head        <= '0;
      tail        <= '0;
      empty       <= 1'b1;
      full        <= 1'b0;
      almost_full <= 1'b0;
    end else begin
      head        <= head_nx;
      tail        <= tail_nx;
      // flags from next occupancy, so enq and deq together are covered
      empty       <= (used_nx == '0);
      full        <= (used_nx == ptr_t'(CMD_USABLE));
      almost_full <= (used_nx >= ptr_t'(CMD_AF_LEVEL));
    end
  end

endmodule

//--- dma_ctrl.sv
module dma_ctrl
  import dma_pkg::*;
(
  input  logic        CLK0,
  input  logic        RST0,
  input  dma_cmd_t    cmd,
  input  logic        cmd_empty,
  output logic        cmd_deq,
  output logic        plan_load,
  output logic        plan_advance,
  output ext_addr_t   cmd_addr,
  output word_count_t cmd_words,
  input  ext_addr_t   cur_addr,
  input  blen_t       burst_len,
  input  logic        plan_done,
  output dma_state_t  state,
  output logic        burst_start,
  input  logic        burst_drained,
  output ext_burst_t  ext_burst,
  input  logic        ext_ready,
  output logic        busy
);

  logic      in_burst;     // burst issued, not yet finished
  logic      cmd_ok;
  logic      ext_en;
  logic      ext_rd_en;
  logic      ext_wr_en;
  ext_addr_t burst_addr;
  blen_t     burst_words;

  // head command is valid while cmd_deq is high, always in idle
  assign cmd_addr  = {cmd.ext_addr[W_EXT_A-1:ADDR_OFFSET], {ADDR_OFFSET{1'b0}}};
  assign cmd_words = cmd.word_size;
  assign cmd_ok    = (cmd.word_size != '0) && (cmd.read_enable || cmd.write_enable);
  assign plan_load = cmd_deq && cmd_ok;  // empty or undirected commands are dropped

  assign ext_en       = ext_rd_en || ext_wr_en;
  assign burst_start  = (state != ST_IDLE) && !in_burst;
  assign plan_advance = in_burst && ext_en && ext_ready;

  assign ext_burst = '{addr:         burst_addr,
                       read_enable:  ext_rd_en,
                       write_enable: ext_wr_en,
                       word_size:    burst_words};

  // --------------------
  // fsm
  // --------------------
  always_ff @(posedge CLK0) begin
    if (RST0) begin
      state     <= ST_IDLE;
      cmd_deq   <= 1'b0;
      in_burst  <= 1'b0;
      ext_rd_en <= 1'b0;
      ext_wr_en <= 1'b0;
    end else begin
      cmd_deq <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (!cmd_deq && !cmd_empty) begin
            cmd_deq <= 1'b1;
          end
          if (plan_load) begin
            // write-to-bram wins if both bits are set
            state <= cmd.write_enable ? ST_WRITE_TO_BRAM : ST_READ_FROM_BRAM;
          end
        end
        ST_WRITE_TO_BRAM, ST_READ_FROM_BRAM: begin
          if (burst_start) begin
            ext_rd_en <= (state == ST_WRITE_TO_BRAM);  // external read feeds bram
            ext_wr_en <= (state == ST_READ_FROM_BRAM);
            in_burst  <= 1'b1;
          end
          if (plan_advance) begin
            ext_rd_en <= 1'b0;
            ext_wr_en <= 1'b0;
          end
          // address accepted and data drained
          if (in_burst && !ext_en && burst_drained) begin
            in_burst <= 1'b0;
            if (plan_done) begin
              state <= ST_IDLE;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // address channel payload
  always_ff @(posedge CLK0) begin
    if (burst_start) begin
      burst_addr  <= cur_addr;
      burst_words <= burst_len;
    end
  end

  always_ff @(posedge CLK0) begin
    if (RST0) begin
      busy <= 1'b0;
    end else begin
      busy <= (state != ST_IDLE) || !cmd_empty;
    end
  end

endmodule

//--- dma_input.txt
// dir (1 ext to bram, 2 bram to ext), byte addr, words, data base, stall, burst count
// then three burst addr / length pairs, unused pairs zero
1 00001fe0 12c 11110000 0 3 00001fe0 008 00002000 100 00002400 024
2 00010000 208 22220000 0 3 00010000 100 00010400 100 00010800 008
1 00000100 000 33330000 0 0 00000000 000 00000000 000 00000000 000
1 00003003 005 44440000 0 1 00003000 005 00000000 000 00000000 000
1 00000ff0 014 55550000 1 2 00000ff0 004 00001000 010 00000000 000
2 00020f00 064 66660000 1 2 00020f00 040 00021000 024 00000000 000

//--- dma_pkg.sv
package dma_pkg;

  // --------------------
  // widths and limits
  // --------------------
  localparam int W_D           = 32;
  localparam int W_EXT_A       = 32;  // byte addressing
  localparam int ADDR_OFFSET   = 2;   // log2 of bytes per word
  localparam int W_BOUNDARY_A  = 12;  // 4 KB burst boundary
  localparam int MAX_BURST_LEN = 256;
  localparam int W_BLEN        = 9;   // holds 0..256

  // words in one boundary window, plus a width that can hold that count
  localparam int BOUNDARY_WORDS = 1 << (W_BOUNDARY_A - ADDR_OFFSET);
  localparam int W_BWORDS       = W_BOUNDARY_A - ADDR_OFFSET + 1;

  // command queue
  localparam int CMD_FIFO_AW  = 4;
  localparam int CMD_SLOTS    = 1 << CMD_FIFO_AW;
  localparam int CMD_USABLE   = CMD_SLOTS - 1;  // one slot kept free
  localparam int CMD_AF_LEVEL = CMD_USABLE - 2;  // two or fewer free

  // --------------------
  // types
  // --------------------
  typedef logic [W_D-1:0]      data_t;
  typedef logic [W_EXT_A-1:0]  ext_addr_t;
  typedef logic [W_EXT_A:0]    word_count_t;
  typedef logic [W_BLEN-1:0]   blen_t;
  typedef logic [W_BWORDS-1:0] bwords_t;

  typedef struct packed {
    ext_addr_t   ext_addr;
    logic        read_enable;   // bram -> external
    logic        write_enable;  // external -> bram
    word_count_t word_size;     // in words
  } dma_cmd_t;

  typedef struct packed {
    ext_addr_t addr;
    logic      read_enable;
    logic      write_enable;
    blen_t     word_size;
  } ext_burst_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITE_TO_BRAM,
    ST_READ_FROM_BRAM
  } dma_state_t;

endpackage

//--- dma_stream_top.sv
module dma_stream_top
  import dma_pkg::*;
(
  input  logic       CLK0,
  input  logic       RST0,

  // request side
  input  dma_cmd_t   req_cmd,
  input  logic       req_valid,
  output logic       req_ready,
  output logic       req_busy,

  // external address channel
  output ext_burst_t ext_burst,
  input  logic       ext_ready,

  // external data channel
  input  data_t      ext_read_data,
  input  logic       ext_read_empty,
  output logic       ext_read_deq,
  output data_t      ext_write_data,
  output logic       ext_write_enq,
  input  logic       ext_write_almost_full,

  // bram side
  input  data_t      core_read_data,
  input  logic       core_read_empty,
  output logic       core_read_enable,
  output data_t      core_write_data,
  output logic       core_write_enable,
  input  logic       core_write_almost_full
);

  dma_cmd_t    head_cmd;
  logic        cmd_empty;
  logic        cmd_almost_full;
  logic        cmd_deq;
  logic        plan_load;
  logic        plan_advance;
  logic        plan_done;
  ext_addr_t   cmd_addr;
  ext_addr_t   cur_addr;
  word_count_t cmd_words;
  blen_t       burst_len;
  dma_state_t  state;
  logic        burst_start;
  logic        burst_drained;

  assign req_ready = !cmd_almost_full;

  cmd_fifo u_cmd_fifo (
    .CLK0        (CLK0),
    .RST0        (RST0),
    .enq         (req_valid),
    .din         (req_cmd),
    .full        (),
    .almost_full (cmd_almost_full),
    .deq         (cmd_deq),
    .dout        (head_cmd),
    .empty       (cmd_empty)
  );

  dma_ctrl u_dma_ctrl (
    .CLK0          (CLK0),
    .RST0          (RST0),
    .cmd           (head_cmd),
    .cmd_empty     (cmd_empty),
    .cmd_deq       (cmd_deq),
    .plan_load     (plan_load),
    .plan_advance  (plan_advance),
    .cmd_addr      (cmd_addr),
    .cmd_words     (cmd_words),
    .cur_addr      (cur_addr),
    .burst_len     (burst_len),
    .plan_done     (plan_done),
    .state         (state),
    .burst_start   (burst_start),
    .burst_drained (burst_drained),
    .ext_burst     (ext_burst),
    .ext_ready     (ext_ready),
    .busy          (req_busy)
  );

  burst_planner u_burst_planner (
    .CLK0         (CLK0),
    .RST0         (RST0),
    .plan_load    (plan_load),
    .cmd_addr     (cmd_addr),
    .cmd_words    (cmd_words),
    .plan_advance (plan_advance),
    .cur_addr     (cur_addr),
    .burst_len    (burst_len),
    .plan_done    (plan_done)
  );

  stream_mover u_stream_mover (
    .CLK0                   (CLK0),
    .RST0                   (RST0),
    .dir                    (state),
    .burst_start            (burst_start),
    .burst_len              (burst_len),
    .burst_drained          (burst_drained),
    .ext_read_data          (ext_read_data),
    .ext_read_empty         (ext_read_empty),
    .ext_read_deq           (ext_read_deq),
    .ext_write_data         (ext_write_data),
    .ext_write_enq          (ext_write_enq),
    .ext_write_almost_full  (ext_write_almost_full),
    .core_read_data         (core_read_data),
    .core_read_empty        (core_read_empty),
    .core_read_enable       (core_read_enable),
    .core_write_data        (core_write_data),
    .core_write_enable      (core_write_enable),
    .core_write_almost_full (core_write_almost_full)
  );

endmodule

//--- filelist.f
dma_pkg.sv
cmd_fifo.sv
burst_planner.sv
stream_mover.sv
dma_ctrl.sv
dma_stream_top.sv
tb_dma_stream.sv

//--- stream_mover.sv
module stream_mover
  import dma_pkg::*;
(
  input  logic       CLK0,
  input  logic       RST0,
  input  dma_state_t dir,
  input  logic       burst_start,
  input  blen_t      burst_len,
  output logic       burst_drained,

  // external data channel
  input  data_t      ext_read_data,
  input  logic       ext_read_empty,
  output logic       ext_read_deq,
  output data_t      ext_write_data,
  output logic       ext_write_enq,
  input  logic       ext_write_almost_full,

  // bram side
  input  data_t      core_read_data,
  input  logic       core_read_empty,
  output logic       core_read_enable,
  output data_t      core_write_data,
  output logic       core_write_enable,
  input  logic       core_write_almost_full
);

  blen_t count;       // words left in this burst
  logic  push_pend;   // bram read issued last cycle
  logic  wr_move;
  logic  rd_move;

  // --------------------
  // transparent enables
  // --------------------
  assign wr_move = (dir == ST_WRITE_TO_BRAM) && (count != '0) &&
                   !ext_read_empty && !core_write_almost_full;

  assign rd_move = (dir == ST_READ_FROM_BRAM) && (count != '0) &&
                   !ext_write_almost_full && !core_read_empty;

  // external -> bram passes straight through
  assign ext_read_deq      = wr_move;
  assign core_write_enable = wr_move;
  assign core_write_data   = ext_read_data;

  // bram -> external, data shows up one cycle after the read
  assign core_read_enable = rd_move;
  assign ext_write_enq    = push_pend;
  assign ext_write_data   = core_read_data;

  assign burst_drained = (count == '0) && !push_pend;

  // --------------------
  // word counter
  // --------------------
  always_ff @(posedge CLK0) begin
    if (RST0) begin
      count     <= '0;
      push_pend <= 1'b0;
    end else begin
      push_pend <= rd_move;
      if (burst_start) begin
        count <= burst_len;
      end else if (wr_move || rd_move) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- tb_dma_stream.sv
module tb_dma_stream
  import dma_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          CLK_PERIOD     = 40;
  localparam int          RESET_CYCLES   = 16;
  localparam logic [31:0] SEED           = 32'hedec_3508;
  localparam int          TIMEOUT_MARGIN = 200;  // cycles per test
  localparam int          REC_WORDS      = 12;   // words per test record
  localparam int          MAX_TESTS      = 16;

  logic       CLK0;
  logic       RST0;
  dma_cmd_t   req_cmd;
  logic       req_valid;
  logic       req_ready;
  logic       req_busy;
  ext_burst_t ext_burst;
  logic       ext_ready;
  data_t      ext_read_data;
  logic       ext_read_empty;
  logic       ext_read_deq;
  data_t      ext_write_data;
  logic       ext_write_enq;
  logic       ext_write_almost_full;
  data_t      core_read_data;
  logic       core_read_empty;
  logic       core_read_enable;
  data_t      core_write_data;
  logic       core_write_enable;
  logic       core_write_almost_full;

  logic [31:0] stim [REC_WORDS*MAX_TESTS];

  // models of the flow partners
  data_t       ext_src_q [$];    // external read fifo contents
  data_t       core_src_q [$];   // bram read side contents
  data_t       ext_sink_q [$];
  data_t       core_sink_q [$];
  logic [31:0] burst_addr_q [$];
  int          burst_len_q [$];
  logic [1:0]  burst_dir_q [$];  // {write_enable, read_enable}
  data_t       core_rd_word;     // bram data, one cycle late
  logic        tracking = 1'b0;  // burst issued, ready not yet given
  int          ready_wait = 0;
  logic        stall_mode = 1'b0;
  logic [31:0] rng = SEED;
  int          cycles = 0;
  int          cycle_limit = 1000000;
  int          errors = 0;
  int          checks = 0;

  dma_stream_top UUT (.*);

  initial begin
    CLK0 = 1'b0;
    forever #(CLK_PERIOD/2) CLK0 = ~CLK0;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic data_t make_word(input data_t base, input int i);
    return base ^ (data_t'(i) * 32'h9e37_79b9);
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
      $display("error: %s", what);
      errors++;
    end
  endtask

  // cycle budget
  always @(posedge CLK0) begin : watchdog
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout: transfer did not finish within %0d cycles", cycle_limit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // --------------------
  // sample at posedge
  // --------------------
  always @(posedge CLK0) begin : monitor
    if (ext_read_deq === 1'b1) begin
      if (ext_src_q.size() > 0) ext_src_q.delete(0);
      else check_true(1'b0, "external read fifo dequeued while empty");
    end
    if (core_write_enable === 1'b1) core_sink_q.push_back(core_write_data);
    if (ext_write_enq === 1'b1) ext_sink_q.push_back(ext_write_data);
    if (core_read_enable === 1'b1) begin
      if (core_src_q.size() > 0) core_rd_word = core_src_q.pop_front();
      else check_true(1'b0, "bram read side read while empty");
    end
    if (ext_burst.read_enable === 1'b1 || ext_burst.write_enable === 1'b1) begin
      if (tracking && ext_ready) begin
        tracking = 1'b0;  // handshake, enable drops now
      end else if (!tracking) begin
        burst_addr_q.push_back(ext_burst.addr);
        burst_len_q.push_back(int'(ext_burst.word_size));
        burst_dir_q.push_back({ext_burst.write_enable, ext_burst.read_enable});
        rng        = lcg_step(rng);
        ready_wait = int'(rng[31:30]);  // 0..3 extra cycles
        tracking   = 1'b1;
      end
    end
  end

  // --------------------
  // drive at negedge
  // --------------------
  always @(negedge CLK0) begin : driver
    logic [3:0] stall;
    if (tracking) begin
      ext_ready = (ready_wait == 0);
      if (ready_wait > 0) ready_wait--;
    end else begin
      ext_ready = 1'b0;
    end
    rng   = lcg_step(rng);
    stall = stall_mode ? rng[31:28] : 4'b0000;
    ext_read_data          = (ext_src_q.size() > 0) ? ext_src_q[0] : '0;
    ext_read_empty         = (ext_src_q.size() == 0) || stall[0];
    core_read_data         = core_rd_word;
    core_read_empty        = (core_src_q.size() == 0) || stall[1];
    ext_write_almost_full  = stall[2];
    core_write_almost_full = stall[3];
  end

  task automatic run_test(input int t);
    int         idx;
    int         words;
    int         nb;
    int         err_before;
    logic [1:0] dir;
    idx        = t * REC_WORDS;
    dir        = stim[idx][1:0];
    words      = int'(stim[idx+2]);
    nb         = int'(stim[idx+5]);
    err_before = errors;
    ext_src_q.delete();
    core_src_q.delete();
    ext_sink_q.delete();
    core_sink_q.delete();
    burst_addr_q.delete();
    burst_len_q.delete();
    burst_dir_q.delete();
    for (int i = 0; i < words; i++) begin
      if (dir == 2'd1) ext_src_q.push_back(make_word(stim[idx+3], i));
      else if (dir == 2'd2) core_src_q.push_back(make_word(stim[idx+3], i));
    end
    stall_mode = stim[idx+4][0];
    @(negedge CLK0);
    check_true(req_ready, "req_ready low before a request");
    req_cmd = '{ext_addr:     stim[idx+1],
                read_enable:  dir[1],
                write_enable: dir[0],
                word_size:    word_count_t'(stim[idx+2])};
    req_valid = 1'b1;  // one-cycle strobe
    @(negedge CLK0);
    req_valid = 1'b0;
    while (!req_busy) @(negedge CLK0);
    while (req_busy) @(negedge CLK0);
    stall_mode = 1'b0;

    check_value("ext_burst count", burst_addr_q.size(), nb);
    for (int b = 0; b < nb && b < burst_addr_q.size(); b++) begin
      check_value("ext_burst.addr", burst_addr_q[b], stim[idx+6+2*b]);
      check_value("ext_burst.word_size", burst_len_q[b], stim[idx+7+2*b]);
      check_value("ext_burst enables", burst_dir_q[b], dir);
    end

    // every word once and in order
    check_value("core_write_enable count", core_sink_q.size(), (dir == 2'd1) ? words : 0);
    check_value("ext_write_enq count", ext_sink_q.size(), (dir == 2'd2) ? words : 0);
    for (int i = 0; i < core_sink_q.size() && i < words; i++) begin
      check_value("core_write_data", core_sink_q[i], make_word(stim[idx+3], i));
    end
    for (int i = 0; i < ext_sink_q.size() && i < words; i++) begin
      check_value("ext_write_data", ext_sink_q[i], make_word(stim[idx+3], i));
    end
    check_true(ext_src_q.size() == 0, "external read fifo not fully drained");
    check_true(core_src_q.size() == 0, "bram read side not fully drained");

    $display("test %0d: dir %0d, addr %h, %0d words, %0d bursts, %0d errors",
             t + 1, dir, stim[idx+1], words, burst_addr_q.size(), errors - err_before);
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin : main
    int n_tests;
    int err_before;
    RST0                   = 1'b1;
    req_cmd                = '0;
    req_valid              = 1'b0;
    ext_ready              = 1'b0;
    ext_read_data          = '0;
    ext_read_empty         = 1'b1;
    ext_write_almost_full  = 1'b0;
    core_read_data         = '0;
    core_read_empty        = 1'b1;
    core_write_almost_full = 1'b0;
    core_rd_word           = '0;

    $readmemh("dma_input.txt", stim);
    n_tests = 0;
    while (n_tests < MAX_TESTS && stim[n_tests*REC_WORDS] !== 'x) n_tests++;
    cycle_limit = RESET_CYCLES + TIMEOUT_MARGIN;
    for (int t = 0; t < n_tests; t++) begin
      cycle_limit += int'(stim[t*REC_WORDS+2]) * 8 + TIMEOUT_MARGIN;
    end
    check_true(n_tests > 0, "no tests found in dma_input.txt");

    repeat (RESET_CYCLES) @(negedge CLK0);
    RST0 = 1'b0;
    @(negedge CLK0);
    err_before = errors;
    check_value("req_busy", req_busy, 1'b0);
    check_value("req_ready", req_ready, 1'b1);
    check_value("ext_burst.read_enable", ext_burst.read_enable, 1'b0);
    check_value("ext_burst.write_enable", ext_burst.write_enable, 1'b0);
    check_value("ext_read_deq", ext_read_deq, 1'b0);
    check_value("ext_write_enq", ext_write_enq, 1'b0);
    check_value("core_read_enable", core_read_enable, 1'b0);
    check_value("core_write_enable", core_write_enable, 1'b0);
    $display("test 0: reset, %0d errors", errors - err_before);

    for (int t = 0; t < n_tests; t++) begin
      run_test(t);
    end

    $display("%0d tests, %0d checks, %0d errors", n_tests + 1, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
